/* include/zx_test_macros.svh */
`ifndef ZX_TEST_MACROS_SVH
`define ZX_TEST_MACROS_SVH

// ------------------------------------------------------------
// service link command codes
// ------------------------------------------------------------

`define CMD_TEMP        8'ha0
`define CMD_FLASH_LO    8'ha3
`define CMD_FLASH_MID   8'ha4
`define CMD_FLASH_HI    8'ha5
`define CMD_FLASH_DATA  8'ha6
`define CMD_FLASH_CTRL  8'ha7
`define CMD_COVOX       8'h53
`define CMD_INT_CTRL    8'h54

// ------------------------------------------------------------
// sizes and timing
// ------------------------------------------------------------

`define FIFO_DEPTH          16
// fifo popped once per 2**n cycles
`define SAMPLE_PERIOD_LOG2  8
`define SYNC_STAGES         2

// reset and idle values
`define READ_IDLE     8'hff
`define SAMPLE_RESET  8'h7f

`endif

/* hw/host_link_pkg.sv */
`default_nettype none

package host_link_pkg;

  // one byte on the serial link
  typedef logic [7:0] spi_byte_t;

  // readback bit position, msb first
  typedef logic [2:0] spi_bitptr_t;

  // command and data byte of one frame
  typedef struct packed {
    spi_byte_t cmd;
    spi_byte_t data;
  } spi_frame_t;

endpackage

`default_nettype wire

/* hw/periph_pkg.sv */
`default_nettype none

package periph_pkg;

  // audio sample, unsigned
  typedef logic [7:0] sample_t;
  typedef logic [3:0] fifo_ptr_t;
  typedef logic [3:0] fifo_level_t;

  typedef logic [18:0] flash_addr_t;
  typedef logic [7:0]  flash_data_t;

  // bit 0 is chip select, bit 3 post-increment
  typedef struct packed {
    logic postinc;
    logic we;
    logic oe;
    logic cs;
  } flash_ctrl_t;

  typedef enum logic [2:0] {
    FLD_ADDR_LO,
    FLD_ADDR_MID,
    FLD_ADDR_HI,
    FLD_DATA,
    FLD_CTRL
  } flash_field_e;

  typedef struct packed {
    logic         strobe;
    flash_field_e field;
    flash_data_t  data;
  } flash_wr_t;

endpackage

`default_nettype wire

/* hw/spi_frame_rx.sv */
`timescale 1ns/1ps
`default_nettype none

`include "zx_test_macros.svh"

module spi_frame_rx
  import host_link_pkg::*;
(
  input  logic       fclk,
  input  logic       rst,
  input  logic       spick,
  input  logic       spics_n,
  input  logic       spido,
  input  spi_byte_t  read_byte,
  output logic       spidi,
  output logic       frame_open,
  output logic       frame_done,
  output spi_frame_t frame
);

  // ------------------------------------------------------------
  // resampling into fclk
  // ------------------------------------------------------------

  // top bit of clock and select chains is the previous level
  logic [`SYNC_STAGES:0]   ck_sh;
  logic [`SYNC_STAGES:0]   cs_sh;
  logic [`SYNC_STAGES-1:0] do_sh;

  logic ck_rise;
  logic ck_fall;
  logic cs_level;
  logic do_level;

  spi_bitptr_t bitptr;

  always_ff @(posedge fclk)
  begin
    if (rst)
    begin
      ck_sh <= '0;
      cs_sh <= '1;
      do_sh <= '0;
    end
    else
    begin
      ck_sh <= {ck_sh[`SYNC_STAGES-1:0], spick};
      cs_sh <= {cs_sh[`SYNC_STAGES-1:0], spics_n};
      do_sh <= {do_sh[`SYNC_STAGES-2:0], spido};
    end
  end

  assign ck_rise  = ck_sh[`SYNC_STAGES-1] & ~ck_sh[`SYNC_STAGES];
  assign ck_fall  = ~ck_sh[`SYNC_STAGES-1] & ck_sh[`SYNC_STAGES];
  assign cs_level = cs_sh[`SYNC_STAGES-1];
  assign do_level = do_sh[`SYNC_STAGES-1];

  assign frame_open = ~cs_sh[`SYNC_STAGES-1] & cs_sh[`SYNC_STAGES];
  assign frame_done = cs_sh[`SYNC_STAGES-1] & ~cs_sh[`SYNC_STAGES];

  // ------------------------------------------------------------
  // byte assembly and readback
  // ------------------------------------------------------------

  // command shifts while deselected, data while selected
  always_ff @(posedge fclk)
  begin
    if (ck_rise)
    begin
      if (cs_level)
        frame.cmd <= {frame.cmd[6:0], do_level};
      else
        frame.data <= {frame.data[6:0], do_level};
    end
  end

  always_ff @(posedge fclk)
  begin
    if (rst || cs_level)
      bitptr <= 3'd7;
    else if (ck_fall)
      bitptr <= bitptr - 3'd1;
  end

  assign spidi = read_byte[bitptr];

endmodule

`default_nettype wire

/* hw/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "zx_test_macros.svh"

module reg_file
  import host_link_pkg::*;
  import periph_pkg::*;
(
  input  logic        fclk,
  input  logic        rst,
  input  logic        frame_open,
  input  logic        frame_done,
  input  spi_frame_t  frame,
  input  fifo_level_t fifo_level,
  input  spi_byte_t   bus_in,
  output spi_byte_t   read_byte,
  output flash_wr_t   flash_wr,
  output logic        sample_wr,
  output sample_t     sample_in,
  output logic        int_en
);

  spi_byte_t scratch;

  // ------------------------------------------------------------
  // register writes at end of frame
  // ------------------------------------------------------------

  always_ff @(posedge fclk)
  begin
    if (rst)
    begin
      flash_wr.strobe <= 1'b0;
      sample_wr       <= 1'b0;
      int_en          <= 1'b0;
    end
    else
    begin
      flash_wr.strobe <= 1'b0;
      sample_wr       <= 1'b0;
      if (frame_done)
      begin
        flash_wr.data <= frame.data;
        case (frame.cmd)
          `CMD_FLASH_LO:
          begin
            flash_wr.strobe <= 1'b1;
            flash_wr.field  <= FLD_ADDR_LO;
          end
          `CMD_FLASH_MID:
          begin
            flash_wr.strobe <= 1'b1;
            flash_wr.field  <= FLD_ADDR_MID;
          end
          `CMD_FLASH_HI:
          begin
            flash_wr.strobe <= 1'b1;
            flash_wr.field  <= FLD_ADDR_HI;
          end
          `CMD_FLASH_DATA:
          begin
            flash_wr.strobe <= 1'b1;
            flash_wr.field  <= FLD_DATA;
          end
          `CMD_FLASH_CTRL:
          begin
            flash_wr.strobe <= 1'b1;
            flash_wr.field  <= FLD_CTRL;
          end
          `CMD_COVOX:
          begin
            sample_wr <= 1'b1;
            sample_in <= frame.data;
          end
          `CMD_TEMP:
            scratch <= frame.data;
          `CMD_INT_CTRL:
            int_en <= frame.data[0];
          default:
          begin
          end
        endcase
      end
    end
  end

  // ------------------------------------------------------------
  // readback byte, chosen as the frame opens
  // ------------------------------------------------------------

  always_ff @(posedge fclk)
  begin
    if (rst)
      read_byte <= `READ_IDLE;
    else if (frame_open)
    begin
      case (frame.cmd)
        `CMD_TEMP:       read_byte <= scratch;
        `CMD_FLASH_DATA: read_byte <= bus_in;
        // fill level in the low nibble
        `CMD_COVOX:      read_byte <= {4'd0, fifo_level};
        default:         read_byte <= `READ_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/covox_dac.sv */
`timescale 1ns/1ps
`default_nettype none

`include "zx_test_macros.svh"

module covox_dac
  import periph_pkg::*;
(
  input  logic        fclk,
  input  logic        rst,
  input  logic        sample_wr,
  input  sample_t     sample_in,
  input  logic        int_en,
  output fifo_level_t fifo_level,
  output logic        beep,
  output logic        spiint_n
);

  sample_t mem [`FIFO_DEPTH];

  fifo_ptr_t wr_ptr;
  fifo_ptr_t rd_ptr;
  fifo_ptr_t wr_next;

  logic [`SAMPLE_PERIOD_LOG2-1:0] timer;
  logic [8:0] err_acc;
  logic [9:0] acc_sum;
  logic push;
  logic pop;

  // ------------------------------------------------------------
  // sample fifo
  // ------------------------------------------------------------

  assign wr_next    = wr_ptr + 4'd1;
  assign fifo_level = wr_ptr - rd_ptr;

  // one slot is the sample being played, full drops the write
  assign push = sample_wr && (fifo_level != fifo_level_t'(`FIFO_DEPTH - 1));
  assign pop  = (&timer) && (wr_ptr != rd_ptr);

  always_ff @(posedge fclk)
  begin
    if (rst)
      mem[0] <= `SAMPLE_RESET;
    else if (push)
      mem[wr_next] <= sample_in;
  end

  // ------------------------------------------------------------
  // delta-sigma, ones density (256 + s) / 512
  // ------------------------------------------------------------

  assign acc_sum = {1'b0, err_acc} + {2'b01, mem[rd_ptr]};

  always_ff @(posedge fclk)
  begin
    if (rst)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      timer    <= '0;
      err_acc  <= '0;
      beep     <= 1'b0;
      spiint_n <= 1'b1;
    end
    else
    begin
      timer <= timer + 1'b1;
      if (push)
        wr_ptr <= wr_next;
      if (pop)
        rd_ptr <= rd_ptr + 4'd1;
      err_acc <= acc_sum[8:0];
      beep    <= acc_sum[9];
      // request refill while under half full, first half of period
      spiint_n <= ~int_en
                | (fifo_level >= fifo_level_t'(`FIFO_DEPTH / 2))
                | timer[`SAMPLE_PERIOD_LOG2-1];
    end
  end

endmodule

`default_nettype wire

/* hw/flash_port.sv */
`timescale 1ns/1ps
`default_nettype none

module flash_port
  import host_link_pkg::*;
  import periph_pkg::*;
(
  input  logic        fclk,
  input  logic        rst,
  input  flash_wr_t   flash_wr,
  output logic [13:0] a,
  output logic        rompg0_n,
  output logic        dos_n,
  output logic        rompg2,
  output logic        rompg3,
  output logic        rompg4,
  output logic        csrom,
  output logic        romoe_n,
  output logic        romwe_n,
  inout  wire logic [7:0] d,
  output spi_byte_t   bus_in
);

  flash_addr_t addr;
  flash_data_t data_out;
  flash_ctrl_t ctrl;

  always_ff @(posedge fclk)
  begin
    if (rst)
    begin
      addr     <= '0;
      data_out <= '0;
      ctrl     <= '0;
    end
    else if (flash_wr.strobe)
    begin
      case (flash_wr.field)
        FLD_ADDR_LO:  addr[7:0]   <= flash_wr.data;
        FLD_ADDR_MID: addr[15:8]  <= flash_wr.data;
        FLD_ADDR_HI:  addr[18:16] <= flash_wr.data[2:0];
        FLD_DATA:
        begin
          data_out <= flash_wr.data;
          // increment stays inside the 16k window
          if (ctrl.postinc)
            addr[13:0] <= addr[13:0] + 14'd1;
        end
        FLD_CTRL:     ctrl <= flash_ctrl_t'(flash_wr.data[3:0]);
        default:
        begin
        end
      endcase
    end
  end

  always_ff @(posedge fclk)
  begin
    bus_in <= d;
  end

  // ------------------------------------------------------------
  // pin mapping
  // ------------------------------------------------------------

  assign a        = addr[13:0];
  assign rompg0_n = ~addr[14];
  assign {rompg4, rompg3, rompg2, dos_n} = addr[18:15];
  assign csrom    = ctrl.cs;
  assign romoe_n  = ~ctrl.oe;
  assign romwe_n  = ~ctrl.we;

  assign d = ctrl.oe ? 8'bzzzz_zzzz : data_out;

endmodule

`default_nettype wire

/* hw/zx_test_top.sv */
`timescale 1ns/1ps
`default_nettype none

module zx_test_top
  import host_link_pkg::*;
  import periph_pkg::*;
(
  input  logic        fclk,
  input  logic        rst,
  input  logic        spick,
  input  logic        spics_n,
  input  logic        spido,
  output logic        spidi,
  output logic        beep,
  output logic        spiint_n,
  output logic [13:0] a,
  output logic        rompg0_n,
  output logic        dos_n,
  output logic        rompg2,
  output logic        rompg3,
  output logic        rompg4,
  output logic        csrom,
  output logic        romoe_n,
  output logic        romwe_n,
  inout  wire logic [7:0] d
);

  logic        frame_open;
  logic        frame_done;
  spi_frame_t  frame;
  spi_byte_t   read_byte;
  spi_byte_t   bus_in;
  flash_wr_t   flash_wr;
  logic        sample_wr;
  sample_t     sample_in;
  logic        int_en;
  fifo_level_t fifo_level;

  spi_frame_rx rx_i (
    .fclk       (fclk),
    .rst        (rst),
    .spick      (spick),
    .spics_n    (spics_n),
    .spido      (spido),
    .read_byte  (read_byte),
    .spidi      (spidi),
    .frame_open (frame_open),
    .frame_done (frame_done),
    .frame      (frame)
  );

  reg_file regs_i (
    .fclk       (fclk),
    .rst        (rst),
    .frame_open (frame_open),
    .frame_done (frame_done),
    .frame      (frame),
    .fifo_level (fifo_level),
    .bus_in     (bus_in),
    .read_byte  (read_byte),
    .flash_wr   (flash_wr),
    .sample_wr  (sample_wr),
    .sample_in  (sample_in),
    .int_en     (int_en)
  );

  covox_dac dac_i (
    .fclk       (fclk),
    .rst        (rst),
    .sample_wr  (sample_wr),
    .sample_in  (sample_in),
    .int_en     (int_en),
    .fifo_level (fifo_level),
    .beep       (beep),
    .spiint_n   (spiint_n)
  );

  flash_port flash_i (
    .fclk       (fclk),
    .rst        (rst),
    .flash_wr   (flash_wr),
    .a          (a),
    .rompg0_n   (rompg0_n),
    .dos_n      (dos_n),
    .rompg2     (rompg2),
    .rompg3     (rompg3),
    .rompg4     (rompg4),
    .csrom      (csrom),
    .romoe_n    (romoe_n),
    .romwe_n    (romwe_n),
    .d          (d),
    .bus_in     (bus_in)
  );

endmodule

`default_nettype wire

/* tb/zx_test_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module zx_test_assert (
  input logic       fclk,
  input logic       rst,
  input logic       frame_open,
  input logic       frame_done,
  input logic       int_en,
  input logic       spiint_n,
  input logic       romoe_n,
  input logic [7:0] d
);

  // ------------------------------------------------------------
  // link framing
  // ------------------------------------------------------------

  frame_pulses_apart: assert property (@(posedge fclk) disable iff (rst)
    !(frame_open && frame_done))
    else $error("frame_open and frame_done high in the same cycle");

  // spiint_n is registered, so one cycle of lag after disable
  irq_masked: assert property (@(posedge fclk) disable iff (rst)
    (!int_en && !$past(int_en)) |-> spiint_n)
    else $error("spiint_n low while interrupts disabled");

  // flash data bus
  bus_driven: assert property (@(posedge fclk) disable iff (rst)
    romoe_n |-> !$isunknown(d))
    else $error("d not driven while romoe_n high");

endmodule

bind zx_test_top zx_test_assert assert_i (
  .fclk       (fclk),
  .rst        (rst),
  .frame_open (frame_open),
  .frame_done (frame_done),
  .int_en     (int_en),
  .spiint_n   (spiint_n),
  .romoe_n    (romoe_n),
  .d          (d)
);

`default_nettype wire

/* tb/zx_test_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "zx_test_macros.svh"

module zx_test_tb
  import host_link_pkg::*;
  import periph_pkg::*;
();

  // run limit in fclk cycles
  localparam int TIMEOUT_CYCLES = 200000;
  localparam int HALF_BIT = 4;

  logic fclk;
  logic rst;
  logic spick;
  logic spics_n;
  logic spido;
  logic spidi;
  logic beep;
  logic spiint_n;
  logic [13:0] a;
  logic rompg0_n;
  logic dos_n;
  logic rompg2;
  logic rompg3;
  logic rompg4;
  logic csrom;
  logic romoe_n;
  logic romwe_n;
  wire logic [7:0] d;
  logic [7:0] d_drive;
  logic d_drive_en;

  int cycle_count = 0;
  int err_count = 0;
  int tests_ok = 0;
  int tests_bad = 0;

  assign d = d_drive_en ? d_drive : 8'bzzzz_zzzz;

  zx_test_top dut_i (
    .fclk     (fclk),
    .rst      (rst),
    .spick    (spick),
    .spics_n  (spics_n),
    .spido    (spido),
    .spidi    (spidi),
    .beep     (beep),
    .spiint_n (spiint_n),
    .a        (a),
    .rompg0_n (rompg0_n),
    .dos_n    (dos_n),
    .rompg2   (rompg2),
    .rompg3   (rompg3),
    .rompg4   (rompg4),
    .csrom    (csrom),
    .romoe_n  (romoe_n),
    .romwe_n  (romwe_n),
    .d        (d)
  );

  initial
  begin
    fclk = 1'b0;
    forever #50 fclk = ~fclk;
  end

  always @(posedge fclk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES)
    begin
      $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // compare tasks
  // ------------------------------------------------------------

  task automatic check_byte(input string name, input spi_byte_t exp, input spi_byte_t act);
    if (act !== exp)
    begin
      $display("[FAIL] t=%0t %s: expected %h, got %h", $time, name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_level(input string name, input fifo_level_t exp,
                             input fifo_level_t act);
    if (act !== exp)
    begin
      $display("[FAIL] t=%0t %s: expected %0d, got %0d", $time, name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_addr(input string name, input flash_addr_t exp,
                            input flash_addr_t act);
    if (act !== exp)
    begin
      $display("[FAIL] t=%0t %s: expected %h, got %h", $time, name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("[FAIL] t=%0t %s: expected %b, got %b", $time, name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_count(input string name, input int lo, input int hi, input int act);
    if (act < lo || act > hi)
    begin
      $display("[FAIL] t=%0t %s: expected %0d..%0d, got %0d", $time, name, lo, hi, act);
      err_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_count == errs_before)
    begin
      tests_ok++;
      $display("test %s: ok", name);
    end
    else
    begin
      tests_bad++;
      $display("test %s: %0d errors", name, err_count - errs_before);
    end
  endtask

  // ------------------------------------------------------------
  // serial link driver
  // ------------------------------------------------------------

  // command while deselected, then data with readback msb first
  task automatic spi_xfer(input spi_byte_t cmd, input spi_byte_t data,
                          output spi_byte_t rd);
    int i;
    @(posedge fclk);
    for (i = 7; i >= 0; i--)
    begin
      spick <= 1'b0;
      spido <= cmd[i];
      repeat (HALF_BIT) @(posedge fclk);
      spick <= 1'b1;
      repeat (HALF_BIT) @(posedge fclk);
    end
    spick <= 1'b0;
    repeat (HALF_BIT) @(posedge fclk);
    spics_n <= 1'b0;
    // readback byte needs 6 cycles after select
    repeat (6) @(posedge fclk);
    for (i = 7; i >= 0; i--)
    begin
      spick <= 1'b0;
      spido <= data[i];
      repeat (HALF_BIT - 1) @(posedge fclk);
      @(negedge fclk);
      rd[i] = spidi;
      @(posedge fclk);
      spick <= 1'b1;
      repeat (HALF_BIT) @(posedge fclk);
    end
    spics_n <= 1'b1;
    repeat (8) @(posedge fclk);
  endtask

  function automatic flash_addr_t pin_addr();
    return {rompg4, rompg3, rompg2, dos_n, ~rompg0_n, a};
  endfunction

  // ------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------

  task automatic test_reset_values();
    int errs;
    spi_byte_t rd;
    errs = err_count;
    @(negedge fclk);
    check_bit("spiint_n", 1'b1, spiint_n);
    check_bit("csrom", 1'b0, csrom);
    check_bit("romoe_n", 1'b1, romoe_n);
    check_bit("romwe_n", 1'b1, romwe_n);
    check_bit("d driven", 1'b0, $isunknown(d));
    check_bit("spidi", 1'b1, spidi);
    spi_xfer(8'h00, 8'h00, rd);
    check_byte("idle readback", `READ_IDLE, rd);
    report_test("reset_values", errs);
  endtask

  task automatic test_scratch();
    int errs;
    spi_byte_t val;
    spi_byte_t rd;
    errs = err_count;
    val = spi_byte_t'($urandom);
    spi_xfer(`CMD_TEMP, val, rd);
    spi_xfer(`CMD_TEMP, ~val, rd);
    check_byte("scratch readback", val, rd);
    report_test("scratch", errs);
  endtask

  task automatic test_flash_pins();
    int errs;
    spi_byte_t lo;
    spi_byte_t mid;
    spi_byte_t hi;
    spi_byte_t rnd;
    spi_byte_t rd;
    errs = err_count;
    lo  = spi_byte_t'($urandom);
    mid = spi_byte_t'($urandom);
    hi  = spi_byte_t'($urandom);
    rnd = spi_byte_t'($urandom);
    spi_xfer(`CMD_FLASH_LO, lo, rd);
    spi_xfer(`CMD_FLASH_MID, mid, rd);
    spi_xfer(`CMD_FLASH_HI, hi, rd);
    spi_xfer(`CMD_FLASH_CTRL, rnd, rd);
    @(negedge fclk);
    check_addr("flash address pins", {hi[2:0], mid, lo}, pin_addr());
    // control byte bit 0 chip select, bit 1 output enable, bit 2 write enable
    check_bit("csrom", rnd[0], csrom);
    check_bit("romoe_n", ~rnd[1], romoe_n);
    check_bit("romwe_n", ~rnd[2], romwe_n);
    report_test("flash_pins", errs);
  endtask

  task automatic test_flash_data();
    int errs;
    int i;
    flash_addr_t addr;
    spi_byte_t mid;
    spi_byte_t hi;
    spi_byte_t val;
    spi_byte_t rd;
    errs = err_count;
    // post-increment, write enable, chip select
    spi_xfer(`CMD_FLASH_CTRL, 8'h0d, rd);
    mid = {2'($urandom), 6'h3f};
    hi  = spi_byte_t'($urandom);
    spi_xfer(`CMD_FLASH_LO, 8'hfe, rd);
    spi_xfer(`CMD_FLASH_MID, mid, rd);
    spi_xfer(`CMD_FLASH_HI, hi, rd);
    addr = {hi[2:0], mid, 8'hfe};
    for (i = 0; i < 4; i++)
    begin
      val = spi_byte_t'($urandom);
      spi_xfer(`CMD_FLASH_DATA, val, rd);
      addr[13:0] = addr[13:0] + 14'd1;
      @(negedge fclk);
      check_byte("d", val, d);
      check_addr("flash address pins", addr, pin_addr());
    end
    // output enable so the flash side can drive the bus
    spi_xfer(`CMD_FLASH_CTRL, 8'h03, rd);
    val = spi_byte_t'($urandom);
    @(posedge fclk);
    d_drive    <= val;
    d_drive_en <= 1'b1;
    spi_xfer(`CMD_FLASH_DATA, 8'h00, rd);
    check_byte("flash bus readback", val, rd);
    @(posedge fclk);
    d_drive_en <= 1'b0;
    spi_xfer(`CMD_FLASH_CTRL, 8'h00, rd);
    report_test("flash_data", errs);
  endtask

  task automatic test_audio();
    int errs;
    int i;
    int ones;
    spi_byte_t s;
    spi_byte_t rd;
    errs = err_count;
    for (i = 0; i < 4; i++)
      spi_xfer(`CMD_COVOX, spi_byte_t'($urandom), rd);
    spi_xfer(`CMD_COVOX, spi_byte_t'($urandom), rd);
    check_byte("covox readback high bits", 8'h00, rd & 8'hf0);
    check_count("fill level", 1, 4, int'(rd[3:0]));
    repeat (16 * 256) @(posedge fclk);
    s = spi_byte_t'($urandom);
    spi_xfer(`CMD_COVOX, s, rd);
    check_level("fill level", 4'd0, fifo_level_t'(rd[3:0]));
    // let the sample reach the modulator
    repeat (300) @(posedge fclk);
    ones = 0;
    for (i = 0; i < 512; i++)
    begin
      @(negedge fclk);
      if (beep === 1'b1)
        ones++;
    end
    check_count("beep ones", 256 + s - 1, 256 + s + 1, ones);
    report_test("audio", errs);
  endtask

  task automatic test_interrupt();
    int errs;
    int n;
    int lows;
    spi_byte_t rd;
    errs = err_count;
    spi_xfer(`CMD_INT_CTRL, 8'h01, rd);
    n = 0;
    @(negedge fclk);
    while (spiint_n !== 1'b0 && n < 256)
    begin
      @(negedge fclk);
      n++;
    end
    check_bit("spiint_n", 1'b0, spiint_n);
    spi_xfer(`CMD_INT_CTRL, 8'h00, rd);
    lows = 0;
    for (n = 0; n < 512; n++)
    begin
      @(negedge fclk);
      if (spiint_n !== 1'b1)
        lows++;
    end
    check_count("spiint_n low cycles", 0, 0, lows);
    report_test("interrupt", errs);
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------

  initial
  begin
    rst        <= 1'b1;
    spick      <= 1'b0;
    spics_n    <= 1'b1;
    spido      <= 1'b0;
    d_drive    <= 8'h00;
    d_drive_en <= 1'b0;
    void'($urandom(13));
    repeat (10) @(posedge fclk);
    rst <= 1'b0;
    repeat (2) @(posedge fclk);

    test_reset_values();
    test_scratch();
    test_flash_pins();
    test_flash_data();
    test_audio();
    test_interrupt();

    $display("tests passed: %0d, failed: %0d", tests_ok, tests_bad);
    if (tests_bad == 0 && err_count == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+include
hw/host_link_pkg.sv
hw/periph_pkg.sv
hw/spi_frame_rx.sv
hw/reg_file.sv
hw/covox_dac.sv
hw/flash_port.sv
hw/zx_test_top.sv
tb/zx_test_assert.sv
tb/zx_test_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the zx_test simulation with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f \
  --top-module zx_test_tb \
  -o zx_test_sim

# the simulation may stop early, the log decides the result
./obj_dir/zx_test_sim > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi
